// File: design/mac_job_controller.sv
// job FSM with start and result handshakes and the shared wrapping read address
`timescale 1ns/1ns
`include "slim_mac_macros.svh"

module mac_job_controller (
    input  logic                           clk,
    input  logic                           rst_n,
    // start handshake
    input  logic                           s_valid,
    output logic                           s_ready,
    // result handshake
    output logic                           m_valid,
    input  logic                           m_ready,
    // buffer read
    output logic                           rd_en,
    output slim_mac_ctrl_pkg::buf_addr_t   rd_addr,
    // pipeline side
    output logic                           mac_valid_in,
    input  logic                           mac_valid_out,
    input  slim_mac_data_pkg::result_vec_t result_word,
    output slim_mac_data_pkg::result_vec_t result
);

    slim_mac_ctrl_pkg::ctrl_state_t state;
    slim_mac_ctrl_pkg::ctrl_state_t next_state;

    // ====================
    // next state
    // ====================
    always_comb begin
        next_state = state;
        case (state)
            slim_mac_ctrl_pkg::IDLE: begin
                // accept on s_valid while idle
                if (s_valid) begin
                    next_state = slim_mac_ctrl_pkg::FETCH;
                end
            end
            // single read cycle
            slim_mac_ctrl_pkg::FETCH: next_state = slim_mac_ctrl_pkg::COMPUTE;
            slim_mac_ctrl_pkg::COMPUTE: begin
                if (mac_valid_out) begin
                    next_state = slim_mac_ctrl_pkg::DONE;
                end
            end
            slim_mac_ctrl_pkg::DONE: begin
                // wait here for as long as m_ready stays low
                if (m_ready) begin
                    next_state = slim_mac_ctrl_pkg::IDLE;
                end
            end
            default: next_state = slim_mac_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= slim_mac_ctrl_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // handshake flags straight from state
    assign s_ready = (state == slim_mac_ctrl_pkg::IDLE);
    assign m_valid = (state == slim_mac_ctrl_pkg::DONE);
    assign rd_en   = (state == slim_mac_ctrl_pkg::FETCH);

    // ====================
    // read address
    // ====================
    // steps when FETCH is left, wraps at buffer depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (rd_en) begin
            if (int'(rd_addr) == `SLIM_WBUF_DEPTH - 1) begin
                rd_addr <= '0;
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // buffer data arrives one cycle after rd_en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac_valid_in <= 1'b0;
        end else begin
            mac_valid_in <= rd_en;
        end
    end

    // capture once, held through back-pressure
    always_ff @(posedge clk) begin
        if (state == slim_mac_ctrl_pkg::COMPUTE && mac_valid_out) begin
            result <= result_word;
        end
    end

    // ====================
    // checks
    // ====================
    a_hold_result: assert property (
        @(posedge clk) disable iff (!rst_n)
        (m_valid && !m_ready) |=> (m_valid && $stable(result))
    ) else $error("result dropped or changed under back-pressure");

    a_ready_valid_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(s_ready && m_valid)
    ) else $error("s_ready and m_valid high together");

endmodule

// File: design/mac_reduce_pipeline.sv
// three-stage multiply, row-sum and cross-array reduction with Q8.8 truncation
`timescale 1ns/1ns
`include "slim_mac_macros.svh"

module mac_reduce_pipeline (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            valid_in,
    input  slim_mac_data_pkg::weight_tile_t tiles [`SLIM_N_ARRAY],
    input  slim_mac_data_pkg::xt_vec_t      xt,
    output logic                            valid_out,
    output slim_mac_data_pkg::result_vec_t  result_word
);

    localparam int T = `SLIM_TILE;
    localparam int D = `SLIM_DATA_W;
    localparam int N = `SLIM_N_ARRAY;

    // unpacked operands
    slim_mac_data_pkg::sample_t w_mat [N][T][T];
    slim_mac_data_pkg::sample_t x_vec [T];

    // stage registers
    slim_mac_data_pkg::acc_t prod_q    [N][T][T];
    slim_mac_data_pkg::acc_t row_sum_d [N][T];
    slim_mac_data_pkg::acc_t row_sum_q [N][T];
    slim_mac_data_pkg::acc_t total_d   [T];
    slim_mac_data_pkg::acc_t shifted_d [T];

    // valid bit per stage, travels with the data
    logic [`SLIM_MAC_LATENCY-1:0] valid_pipe;

    // ====================
    // unpack
    // ====================
    // row-major slots in the tile word
    always_comb begin
        for (int a = 0; a < N; a++) begin
            for (int i = 0; i < T; i++) begin
                for (int j = 0; j < T; j++) begin
                    w_mat[a][i][j] = tiles[a][(i*T+j)*D +: D];
                end
            end
        end
        for (int j = 0; j < T; j++) begin
            x_vec[j] = xt[j*D +: D];
        end
    end

    // ====================
    // stage 1 products
    // ====================
    // 16x16 signed fits 32 bits exactly
    // same xt broadcast to every array
    always_ff @(posedge clk) begin
        if (valid_in) begin
            for (int a = 0; a < N; a++) begin
                for (int i = 0; i < T; i++) begin
                    for (int j = 0; j < T; j++) begin
                        prod_q[a][i][j] <= slim_mac_data_pkg::acc_t'(w_mat[a][i][j]) *
                                           slim_mac_data_pkg::acc_t'(x_vec[j]);
                    end
                end
            end
        end
    end

    // ====================
    // stage 2 row sums
    // ====================
    // per array, per row, wraps at acc width
    always_comb begin
        for (int a = 0; a < N; a++) begin
            for (int i = 0; i < T; i++) begin
                row_sum_d[a][i] = '0;
                for (int j = 0; j < T; j++) begin
                    row_sum_d[a][i] = row_sum_d[a][i] + prod_q[a][i][j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_pipe[0]) begin
            row_sum_q <= row_sum_d;
        end
    end

    // ====================
    // stage 3 reduce
    // ====================
    // add the four arrays row by row
    // arithmetic shift drops the fraction bits
    always_comb begin
        for (int i = 0; i < T; i++) begin
            total_d[i] = '0;
            for (int a = 0; a < N; a++) begin
                total_d[i] = total_d[i] + row_sum_q[a][i];
            end
            shifted_d[i] = total_d[i] >>> `SLIM_FRAC_BITS;
        end
    end

    // keep the low sample width only
    always_ff @(posedge clk) begin
        if (valid_pipe[1]) begin
            for (int i = 0; i < T; i++) begin
                result_word[i*D +: D] <= shifted_d[i][D-1:0];
            end
        end
    end

    // valid shift chain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[`SLIM_MAC_LATENCY-2:0], valid_in};
        end
    end

    assign valid_out = valid_pipe[`SLIM_MAC_LATENCY-1];

    // fixed latency both ways
    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_out == $past(valid_in, `SLIM_MAC_LATENCY)
    ) else $error("mac pipeline valid_out does not follow valid_in by the fixed latency");

endmodule

// File: design/slim_mac_ctrl_pkg.sv
// control types of the tile MAC job sequencing
`include "slim_mac_macros.svh"

package slim_mac_ctrl_pkg;

    // job FSM states
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        COMPUTE,
        DONE
    } ctrl_state_t;

    // address into weight banks and xt buffer
    typedef logic [`SLIM_ADDR_W-1:0] buf_addr_t;

    // selects one weight bank on writes
    typedef logic [$clog2(`SLIM_N_ARRAY)-1:0] bank_idx_t;

endpackage

// File: design/slim_mac_data_pkg.sv
// numeric data types of the tile MAC datapath
`include "slim_mac_macros.svh"

package slim_mac_data_pkg;

    // ====================
    // scalars
    // ====================
    // one Q8.8 sample
    typedef logic signed [`SLIM_DATA_W-1:0] sample_t;

    // products and row sums, wraps at 32 bits
    typedef logic signed [`SLIM_ACC_W-1:0] acc_t;

    // ====================
    // packed words
    // ====================
    // row-major tile, element (i,j) at slot i*TILE+j
    typedef logic [`SLIM_TILE*`SLIM_TILE*`SLIM_DATA_W-1:0] weight_tile_t;

    // broadcast input vector, element j at slot j
    typedef logic [`SLIM_TILE*`SLIM_DATA_W-1:0] xt_vec_t;

    // shifted and truncated outputs, element i at slot i
    typedef logic [`SLIM_TILE*`SLIM_DATA_W-1:0] result_vec_t;

endpackage

// File: design/slim_mac_macros.svh
// size constants shared by the tile MAC engine
`ifndef SLIM_MAC_MACROS_SVH
`define SLIM_MAC_MACROS_SVH

// ====================
// tile geometry
// ====================
// edge of a square weight tile
`define SLIM_TILE        4
// signed Q8.8 sample
`define SLIM_DATA_W      16
`define SLIM_ACC_W       32
`define SLIM_FRAC_BITS   8

// ====================
// arrays and buffers
// ====================
// one weight bank per MAC array
`define SLIM_N_ARRAY     4
`define SLIM_WBUF_DEPTH  16
`define SLIM_XBUF_DEPTH  16
// shared by both buffers
`define SLIM_ADDR_W      4

// registered stages from mac_valid_in to mac_valid_out
`define SLIM_MAC_LATENCY 3

`endif

// File: design/slim_mac_top.sv
// tile MAC engine top joining buffers, MAC pipeline and job controller
`timescale 1ns/1ns
`include "slim_mac_macros.svh"

module slim_mac_top (
    input  logic                            clk,
    input  logic                            rst_n,
    // start handshake
    input  logic                            s_valid,
    output logic                            s_ready,
    // result handshake
    output logic                            m_valid,
    input  logic                            m_ready,
    output slim_mac_data_pkg::result_vec_t  result,
    // weight load
    input  logic                            w_wr_en,
    input  slim_mac_ctrl_pkg::bank_idx_t    w_wr_bank,
    input  slim_mac_ctrl_pkg::buf_addr_t    w_wr_addr,
    input  slim_mac_data_pkg::weight_tile_t w_wr_data,
    // xt load
    input  logic                            x_wr_en,
    input  slim_mac_ctrl_pkg::buf_addr_t    x_wr_addr,
    input  slim_mac_data_pkg::xt_vec_t      x_wr_data
);

    // controller to buffers
    logic                            rd_en;
    slim_mac_ctrl_pkg::buf_addr_t    rd_addr;
    // buffers to pipeline
    slim_mac_data_pkg::weight_tile_t rd_tiles [`SLIM_N_ARRAY];
    slim_mac_data_pkg::xt_vec_t      rd_vec;
    // pipeline and controller
    logic                            mac_valid_in;
    logic                            mac_valid_out;
    slim_mac_data_pkg::result_vec_t  result_word;

    // ====================
    // buffers
    // ====================
    weight_bank_buffer u_wbuf (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (w_wr_en),
        .wr_bank  (w_wr_bank),
        .wr_addr  (w_wr_addr),
        .wr_data  (w_wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_tiles (rd_tiles)
    );

    // same read address as the weight banks
    xt_vector_buffer u_xbuf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (x_wr_en),
        .wr_addr (x_wr_addr),
        .wr_data (x_wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_vec  (rd_vec)
    );

    // ====================
    // datapath and control
    // ====================
    mac_reduce_pipeline u_mac (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (mac_valid_in),
        .tiles       (rd_tiles),
        .xt          (rd_vec),
        .valid_out   (mac_valid_out),
        .result_word (result_word)
    );

    mac_job_controller u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .m_valid       (m_valid),
        .m_ready       (m_ready),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .mac_valid_in  (mac_valid_in),
        .mac_valid_out (mac_valid_out),
        .result_word   (result_word),
        .result        (result)
    );

endmodule

// File: design/weight_bank_buffer.sv
// four weight tile banks with a bank-selected write and a shared synchronous read
`timescale 1ns/1ns
`include "slim_mac_macros.svh"

module weight_bank_buffer (
    input  logic                            clk,
    input  logic                            rst_n,
    // write port, one tile into one bank
    input  logic                            wr_en,
    input  slim_mac_ctrl_pkg::bank_idx_t    wr_bank,
    input  slim_mac_ctrl_pkg::buf_addr_t    wr_addr,
    input  slim_mac_data_pkg::weight_tile_t wr_data,
    // read port, same address in every bank
    input  logic                            rd_en,
    input  slim_mac_ctrl_pkg::buf_addr_t    rd_addr,
    output slim_mac_data_pkg::weight_tile_t rd_tiles [`SLIM_N_ARRAY]
);

    // ====================
    // storage
    // ====================
    // bank index first, then tile address
    slim_mac_data_pkg::weight_tile_t mem [`SLIM_N_ARRAY][`SLIM_WBUF_DEPTH];

    // write goes to the selected bank only
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_data;
        end
    end

    // ====================
    // read
    // ====================
    // all banks read in parallel
    // one tile per array, one cycle later
    // outputs hold between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int a = 0; a < `SLIM_N_ARRAY; a++) begin
                rd_tiles[a] <= mem[a][rd_addr];
            end
        end
    end

    // write must land inside a bank that exists
    a_wr_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> (int'(wr_addr) < `SLIM_WBUF_DEPTH) && (int'(wr_bank) < `SLIM_N_ARRAY)
    ) else $error("weight bank write out of range");

    // loads happen only while the engine is idle, never during its fetch
    a_no_wr_during_rd: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr_en && rd_en)
    ) else $error("weight bank written during a job read");

endmodule

// File: design/xt_vector_buffer.sv
// input vector memory with a registered synchronous read
`timescale 1ns/1ns
`include "slim_mac_macros.svh"

module xt_vector_buffer (
    input  logic                         clk,
    input  logic                         rst_n,
    // write port
    input  logic                         wr_en,
    input  slim_mac_ctrl_pkg::buf_addr_t wr_addr,
    input  slim_mac_data_pkg::xt_vec_t   wr_data,
    // read port
    input  logic                         rd_en,
    input  slim_mac_ctrl_pkg::buf_addr_t rd_addr,
    output slim_mac_data_pkg::xt_vec_t   rd_vec
);

    // one vector per word
    slim_mac_data_pkg::xt_vec_t mem [`SLIM_XBUF_DEPTH];

    // ====================
    // write
    // ====================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ====================
    // read
    // ====================
    // zero until the first job reads
    // then holds the last vector fetched
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vec <= '0;
        end else if (rd_en) begin
            rd_vec <= mem[rd_addr];
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the tile MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module slim_mac_tb \
    -f slim_mac.f --Mdir obj_dir -o slim_mac_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/slim_mac_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx 'All tests passed!'; then
    exit 0
fi
exit 1

// File: sim/slim_mac_tb_tasks.svh
// driver, wait and compare tasks for the tile MAC engine testbench
`ifndef SLIM_MAC_TB_TASKS_SVH
`define SLIM_MAC_TB_TASKS_SVH

// ====================
// compare
// ====================
task automatic check_result(input slim_mac_data_pkg::result_vec_t got,
                            input slim_mac_data_pkg::result_vec_t exp,
                            input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("mismatch at %0t ns: %s, got %b expected %b", $time, what, got, exp);
    end
endtask

// ====================
// buffer loads
// ====================
// two edges per write, model copy follows
task automatic write_tile(input slim_mac_ctrl_pkg::bank_idx_t bank,
                          input slim_mac_ctrl_pkg::buf_addr_t addr,
                          input slim_mac_data_pkg::weight_tile_t data);
    @(posedge clk);
    w_wr_en   <= 1'b1;
    w_wr_bank <= bank;
    w_wr_addr <= addr;
    w_wr_data <= data;
    @(posedge clk);
    w_wr_en <= 1'b0;
    w_model[bank][addr] = data;
endtask

task automatic write_vec(input slim_mac_ctrl_pkg::buf_addr_t addr,
                         input slim_mac_data_pkg::xt_vec_t data);
    @(posedge clk);
    x_wr_en   <= 1'b1;
    x_wr_addr <= addr;
    x_wr_data <= data;
    @(posedge clk);
    x_wr_en <= 1'b0;
    x_model[addr] = data;
endtask

// ====================
// waits
// ====================
// flags sampled on the falling edge, away from the drive edge
task automatic wait_s_ready(input string what);
    int cycles;
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (s_ready !== 1'b1 && cycles < READY_TIMEOUT);
    if (s_ready !== 1'b1) begin
        $display("timeout: s_ready stayed low while waiting %s", what);
        timeout_count++;
        finish_run();
    end
endtask

// counts rising edges after the accepting edge
// each one sampled on the falling edge that follows it
task automatic wait_m_valid(output int cycles);
    cycles = 0;
    @(negedge clk);
    while (m_valid !== 1'b1 && cycles < JOB_TIMEOUT) begin
        @(negedge clk);
        cycles++;
    end
    if (m_valid !== 1'b1) begin
        $display("timeout: m_valid stayed low for %0d cycles after a job start", cycles);
        timeout_count++;
        finish_run();
    end
endtask

// one start handshake, returns the first valid result
task automatic run_job(output slim_mac_data_pkg::result_vec_t got);
    int cycles;
    @(posedge clk);
    s_valid <= 1'b1;
    wait_s_ready("to start a job");
    // accepted on this edge
    @(posedge clk);
    s_valid <= 1'b0;
    wait_m_valid(cycles);
    if (cycles != JOB_LATENCY) begin
        mismatch_count++;
        $display("mismatch at %0t ns: job %0d took %0d cycles, expected %0d",
                 $time, job_count, cycles, JOB_LATENCY);
    end
    got = result;
    job_count++;
endtask

`endif

// File: sim/slim_mac_tb.sv
// testbench for the tile MAC engine with a reference model and directed tests
`timescale 1ns/1ns
`include "slim_mac_macros.svh"

module slim_mac_tb;

    localparam int T             = `SLIM_TILE;
    localparam int D             = `SLIM_DATA_W;
    localparam int JOB_LATENCY   = 2 + `SLIM_MAC_LATENCY;
    localparam int JOB_TIMEOUT   = 50;
    localparam int READY_TIMEOUT = 50;
    localparam int WRAP_JOBS     = 17;
    localparam int unsigned RAND_SEED = 32'h1ee4_ae75;

    logic                            clk;
    logic                            rst_n;
    logic                            s_valid;
    logic                            s_ready;
    logic                            m_valid;
    logic                            m_ready;
    slim_mac_data_pkg::result_vec_t  result;
    logic                            w_wr_en;
    slim_mac_ctrl_pkg::bank_idx_t    w_wr_bank;
    slim_mac_ctrl_pkg::buf_addr_t    w_wr_addr;
    slim_mac_data_pkg::weight_tile_t w_wr_data;
    logic                            x_wr_en;
    slim_mac_ctrl_pkg::buf_addr_t    x_wr_addr;
    slim_mac_data_pkg::xt_vec_t      x_wr_data;

    // copies of the buffer contents
    slim_mac_data_pkg::weight_tile_t w_model [`SLIM_N_ARRAY][`SLIM_WBUF_DEPTH];
    slim_mac_data_pkg::xt_vec_t      x_model [`SLIM_XBUF_DEPTH];
    int job_count;
    int mismatch_count;
    int timeout_count;
    int unsigned seed_ret;

    slim_mac_top slim_mac_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .result    (result),
        .w_wr_en   (w_wr_en),
        .w_wr_bank (w_wr_bank),
        .w_wr_addr (w_wr_addr),
        .w_wr_data (w_wr_data),
        .x_wr_en   (x_wr_en),
        .x_wr_addr (x_wr_addr),
        .x_wr_data (x_wr_data)
    );

    `include "slim_mac_tb_tasks.svh"

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ====================
    // reference model
    // ====================
    // exact sum, then keep 32 bits and floor-divide by 2^frac
    function automatic slim_mac_data_pkg::result_vec_t expected_result(
            input slim_mac_ctrl_pkg::buf_addr_t addr);
        slim_mac_data_pkg::result_vec_t res;
        longint sum;
        int acc;
        int w;
        int x;
        for (int i = 0; i < T; i++) begin
            sum = 0;
            for (int a = 0; a < `SLIM_N_ARRAY; a++) begin
                for (int j = 0; j < T; j++) begin
                    w = int'(shortint'(w_model[a][addr][(i*T+j)*D +: D]));
                    x = int'(shortint'(x_model[addr][j*D +: D]));
                    sum += longint'(w) * longint'(x);
                end
            end
            acc = int'(sum);
            acc = acc >>> `SLIM_FRAC_BITS;
            res[i*D +: D] = acc[D-1:0];
        end
        return res;
    endfunction

    function automatic slim_mac_data_pkg::weight_tile_t random_tile();
        slim_mac_data_pkg::weight_tile_t t;
        for (int k = 0; k < T*T*D/32; k++) begin
            t[k*32 +: 32] = $urandom();
        end
        return t;
    endfunction

    // address that the next job reads
    function automatic slim_mac_ctrl_pkg::buf_addr_t next_addr();
        return slim_mac_ctrl_pkg::buf_addr_t'(job_count % `SLIM_WBUF_DEPTH);
    endfunction

    task automatic load_random(input slim_mac_ctrl_pkg::buf_addr_t addr);
        for (int a = 0; a < `SLIM_N_ARRAY; a++) begin
            write_tile(slim_mac_ctrl_pkg::bank_idx_t'(a), addr, random_tile());
        end
        write_vec(addr, {$urandom(), $urandom()});
    endtask

    task automatic finish_run();
        $display("error counts: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic test_reset_state();
        @(negedge clk);
        check_bit(m_valid, 1'b0, "m_valid after reset");
        check_bit(s_ready, 1'b1, "s_ready after reset");
    endtask

    task automatic test_single_job();
        slim_mac_data_pkg::result_vec_t exp;
        slim_mac_data_pkg::result_vec_t got;
        load_random(next_addr());
        exp = expected_result(next_addr());
        run_job(got);
        check_result(got, exp, "single job result");
    endtask

    // result parked in DONE while m_ready is low
    task automatic test_back_pressure();
        slim_mac_data_pkg::result_vec_t exp;
        slim_mac_data_pkg::result_vec_t got;
        int hold;
        load_random(next_addr());
        exp = expected_result(next_addr());
        hold = $urandom_range(20, 3);
        @(posedge clk);
        m_ready <= 1'b0;
        run_job(got);
        check_result(got, exp, "back-pressure result");
        repeat (hold) begin
            @(negedge clk);
            check_bit(m_valid, 1'b1, "m_valid under back-pressure");
            check_bit(s_ready, 1'b0, "s_ready under back-pressure");
            check_result(result, exp, "result held under back-pressure");
        end
        @(posedge clk);
        m_ready <= 1'b1;
        wait_s_ready("after the result handshake");
        check_bit(m_valid, 1'b0, "m_valid after the result handshake");
    endtask

    // 17 jobs walk past the end of the buffers
    task automatic test_address_wrap();
        slim_mac_data_pkg::result_vec_t got;
        slim_mac_data_pkg::result_vec_t first;
        for (int k = 0; k < `SLIM_WBUF_DEPTH; k++) begin
            load_random(slim_mac_ctrl_pkg::buf_addr_t'(k));
        end
        for (int n = 0; n < WRAP_JOBS; n++) begin
            run_job(got);
            check_result(got, expected_result(slim_mac_ctrl_pkg::buf_addr_t'(
                         (job_count - 1) % `SLIM_WBUF_DEPTH)), "address sequence result");
            if (n == 0) begin
                first = got;
            end
        end
        check_result(got, first, "wrapped job repeats the first");
    endtask

    // same tile in every bank, optional hand-worked value
    task automatic run_directed(input slim_mac_data_pkg::weight_tile_t tile,
                                input slim_mac_data_pkg::xt_vec_t vec,
                                input logic has_known,
                                input slim_mac_data_pkg::result_vec_t known,
                                input string what);
        slim_mac_data_pkg::result_vec_t got;
        slim_mac_ctrl_pkg::buf_addr_t addr;
        addr = next_addr();
        for (int a = 0; a < `SLIM_N_ARRAY; a++) begin
            write_tile(slim_mac_ctrl_pkg::bank_idx_t'(a), addr, tile);
        end
        write_vec(addr, vec);
        run_job(got);
        check_result(got, expected_result(addr), what);
        if (has_known) begin
            check_result(got, known, what);
        end
    endtask

    task automatic test_sign_extremes();
        // 16 products of 2^30 wrap to zero
        run_directed({16{16'h8000}}, {4{16'h8000}}, 1'b1, '0, "all most-negative");
        // wrapped sum 0x80000, shifted to 0x0800
        run_directed({16{16'h8000}}, {4{16'h7fff}}, 1'b1, {4{16'h0800}}, "min times max");
        // -16 shifts to -1
        run_directed({16{16'h0001}}, {4{16'hffff}}, 1'b1, {4{16'hffff}}, "small negative");
        run_directed({8{16'h7fff, 16'h8001}}, {16'h8000, 16'h7fff, 16'hc000, 16'h4000},
                     1'b0, '0, "mixed signs");
    endtask

    // ====================
    // sequence
    // ====================
    initial begin
        seed_ret = $urandom(RAND_SEED);
        job_count      = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        rst_n     <= 1'b0;
        s_valid   <= 1'b0;
        m_ready   <= 1'b1;
        w_wr_en   <= 1'b0;
        w_wr_bank <= '0;
        w_wr_addr <= '0;
        w_wr_data <= '0;
        x_wr_en   <= 1'b0;
        x_wr_addr <= '0;
        x_wr_data <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_single_job();
        test_back_pressure();
        test_address_wrap();
        test_sign_extremes();
        finish_run();
    end

endmodule

// File: slim_mac.f
+incdir+design
+incdir+sim
design/slim_mac_data_pkg.sv
design/slim_mac_ctrl_pkg.sv
design/weight_bank_buffer.sv
design/xt_vector_buffer.sv
design/mac_reduce_pipeline.sv
design/mac_job_controller.sv
design/slim_mac_top.sv
sim/slim_mac_tb.sv
